// File: filelist.f
logic/spi_pkg.sv
logic/spi_slave_shifter.sv
logic/spi_cmd_decoder.sv
logic/spi_reg_bank.sv
logic/spi_reg_slave.sv
test/tb_spi_reg_slave.sv

// File: logic/spi_cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_decoder (
  input  wire logic                            rst,         // system clock
  input  wire logic                            clk,         // async active high reset
  input  wire logic                            rx_valid,
  input  wire logic [spi_pkg::word_width-1:0]  rx_word,
  input  wire logic                            frame_start,
  input  wire logic                            frame_end,
  input  wire logic [spi_pkg::word_width-1:0]  rd_data,     // combinational from the bank
  output logic      [spi_pkg::word_width-1:0]  tx_word,
  output logic                                 wr_en,
  output logic      [spi_pkg::addr_width-1:0]  wr_addr,
  output logic      [spi_pkg::word_width-1:0]  wr_data,
  output logic      [spi_pkg::addr_width-1:0]  rd_addr
);

  spi_pkg::dec_state_e            state;
  logic [spi_pkg::addr_width-1:0] ptr;      // auto increment address that wraps mod 16

  ////////////////////////////////////////
  // command word fields
  ////////////////////////////////////////
  spi_pkg::spi_op_e               cmd_op;
  logic [spi_pkg::addr_width-1:0] cmd_addr;

  assign cmd_op   = spi_pkg::spi_op_e'(rx_word[spi_pkg::word_width-1 -: 2]); // bits 7:6
  assign cmd_addr = rx_word[spi_pkg::addr_width-1:0];                        // bits 3:0
  // bits 5:4 are don't care

  // the command word reads its own address from the bank
  always_comb begin
    if (state == spi_pkg::st_cmd) begin
      rd_addr = cmd_addr;
    end else begin
      rd_addr = ptr;
    end
  end

  // write request in the same cycle as the data word
  assign wr_en   = rx_valid & (state == spi_pkg::st_write);
  assign wr_addr = ptr;
  assign wr_data = rx_word;

  ////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state   <= spi_pkg::st_cmd;
      ptr     <= '0;
      tx_word <= '0;
    end else if (frame_end || frame_start) begin
      state   <= spi_pkg::st_cmd;  // every frame begins with a command
      tx_word <= '0;               // so first word of a frame sends 0
    end else if (rx_valid) begin
      case (state)
        spi_pkg::st_cmd: begin
          case (cmd_op)
            spi_pkg::op_write: begin
              state <= spi_pkg::st_write;
              ptr   <= cmd_addr;
            end
            spi_pkg::op_read: begin
              state   <= spi_pkg::st_read;
              tx_word <= rd_data;  // data for the next word slot
              ptr     <= cmd_addr + 1'b1;
            end
            default: begin
              state <= spi_pkg::st_skip; // 00 and 11 are ignored
            end
          endcase
        end
        spi_pkg::st_write: begin
          ptr <= ptr + 1'b1;       // bank took the word this cycle
        end
        spi_pkg::st_read: begin
          tx_word <= rd_data;
          ptr     <= ptr + 1'b1;
        end
        spi_pkg::st_skip: begin
          // ignored frame waits here until cs_n rises
        end
        default: begin
          state <= spi_pkg::st_cmd;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/spi_pkg.sv
`default_nettype none

package spi_pkg;

  ////////////////////////////////////////
  // word and register bank geometry
  ////////////////////////////////////////
  localparam int word_width = 8;                  // bits per spi word
  localparam int addr_width = 4;                  // register address bits
  localparam int reg_count  = 16;                 // registers in the bank
  localparam int cnt_width  = $clog2(word_width); // bit counter in the shifter

  // identification register, read only
  localparam logic [addr_width-1:0] id_addr  = 4'd15;
  localparam logic [word_width-1:0] id_value = 8'hA5;

  // opcode in command bits 7:6, anything unnamed is treated as op_none
  typedef enum logic [1:0] {
    op_none  = 2'b00,
    op_write = 2'b01,
    op_read  = 2'b10
  } spi_op_e;

  // frame decoder states
  typedef enum logic [1:0] {
    st_cmd,   // waiting for command word
    st_write, // data words go to the bank
    st_read,  // data words come from the bank
    st_skip   // ignored frame
  } dec_state_e;

endpackage

`default_nettype wire

// File: logic/spi_reg_bank.sv
`timescale 1ns/1ns
`default_nettype none

module spi_reg_bank (
  input  wire logic                            rst,       // system clock
  input  wire logic                            clk,       // async reset, active high
  input  wire logic                            wr_en,
  input  wire logic [spi_pkg::addr_width-1:0]  wr_addr,
  input  wire logic [spi_pkg::word_width-1:0]  wr_data,
  input  wire logic [spi_pkg::addr_width-1:0]  rd_addr,
  output logic      [spi_pkg::word_width-1:0]  rd_data,
  output logic                                 reg_write, // system side strobe
  output logic      [spi_pkg::addr_width-1:0]  reg_addr,
  output logic      [spi_pkg::word_width-1:0]  reg_data
);

  logic [spi_pkg::word_width-1:0] regs [spi_pkg::reg_count];
  logic                           wr_accept;

  // id register never takes a write
  assign wr_accept = wr_en & (wr_addr != spi_pkg::id_addr);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      for (int i = 0; i < spi_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_accept) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // combinational read, id constant overlays address 15
  assign rd_data = (rd_addr == spi_pkg::id_addr) ? spi_pkg::id_value : regs[rd_addr];

  ////////////////////////////////////////
  // write report to the system side
  ////////////////////////////////////////
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      reg_write <= 1'b0;
    end else begin
      reg_write <= wr_accept;      // one cycle after wr_en
    end
  end

  always_ff @(posedge rst) begin
    if (wr_accept) begin
      reg_addr <= wr_addr;
      reg_data <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/spi_reg_slave.sv
`timescale 1ns/1ns
`default_nettype none

module spi_reg_slave (
  input  wire logic                            rst,       // system clock
  input  wire logic                            clk,       // async reset, active high
  input  wire logic                            sclk,      // spi mode 1
  input  wire logic                            mosi,
  input  wire logic                            cs_n,
  output logic                                 miso,
  output logic                                 reg_write,
  output logic      [spi_pkg::addr_width-1:0]  reg_addr,
  output logic      [spi_pkg::word_width-1:0]  reg_data
);

  // shifter <-> decoder
  logic                           rx_valid;
  logic [spi_pkg::word_width-1:0] rx_word;
  logic                           frame_start;
  logic                           frame_end;
  logic [spi_pkg::word_width-1:0] tx_word;

  // decoder <-> bank
  logic                           wr_en;
  logic [spi_pkg::addr_width-1:0] wr_addr;
  logic [spi_pkg::word_width-1:0] wr_data;
  logic [spi_pkg::addr_width-1:0] rd_addr;
  logic [spi_pkg::word_width-1:0] rd_data;

  ////////////////////////////////////////
  // spi serial side
  ////////////////////////////////////////
  spi_slave_shifter shifter0 (
    .rst(rst), .clk(clk),
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
    .tx_word(tx_word), .miso(miso),
    .rx_valid(rx_valid), .rx_word(rx_word),
    .frame_start(frame_start), .frame_end(frame_end)
  );

  spi_cmd_decoder decoder0 (
    .rst(rst), .clk(clk),
    .rx_valid(rx_valid), .rx_word(rx_word),
    .frame_start(frame_start), .frame_end(frame_end),
    .rd_data(rd_data), .tx_word(tx_word),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr(rd_addr)
  );

  spi_reg_bank bank0 (
    .rst(rst), .clk(clk),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr(rd_addr), .rd_data(rd_data),
    .reg_write(reg_write), .reg_addr(reg_addr), .reg_data(reg_data)
  );

endmodule

`default_nettype wire

// File: logic/spi_slave_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module spi_slave_shifter (
  input  wire logic                            rst,         // system clock
  input  wire logic                            clk,         // async reset, active high
  input  wire logic                            sclk,
  input  wire logic                            mosi,
  input  wire logic                            cs_n,
  input  wire logic [spi_pkg::word_width-1:0]  tx_word,     // next word to send
  output logic                                 miso,
  output logic                                 rx_valid,    // one cycle per full word
  output logic      [spi_pkg::word_width-1:0]  rx_word,
  output logic                                 frame_start, // cs_n fell
  output logic                                 frame_end    // cs_n rose
);

  ////////////////////////////////////////
  // input synchronizers
  ////////////////////////////////////////
  logic sclk_meta, sclk_sync, sclk_prev;
  logic cs_meta, cs_sync, cs_prev;
  logic mosi_meta, mosi_sync;       // same depth as sclk so bits line up

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      sclk_meta <= 1'b0;
      sclk_sync <= 1'b0;
      sclk_prev <= 1'b0;
      cs_meta   <= 1'b1;            // deselected out of reset
      cs_sync   <= 1'b1;
      cs_prev   <= 1'b1;
      mosi_meta <= 1'b0;
      mosi_sync <= 1'b0;
    end else begin
      sclk_meta <= sclk;
      sclk_sync <= sclk_meta;
      sclk_prev <= sclk_sync;       // edge detect stage
      cs_meta   <= cs_n;
      cs_sync   <= cs_meta;
      cs_prev   <= cs_sync;
      mosi_meta <= mosi;
      mosi_sync <= mosi_meta;
    end
  end

  // edges, sclk only counts while selected
  logic sclk_rise, sclk_fall, cs_fall, cs_rise;
  assign sclk_rise = sclk_sync & ~sclk_prev & ~cs_sync;
  assign sclk_fall = ~sclk_sync & sclk_prev & ~cs_sync;
  assign cs_fall   = ~cs_sync & cs_prev;
  assign cs_rise   = cs_sync & ~cs_prev;

  ////////////////////////////////////////
  // receive side, mosi sampled on falling sclk
  ////////////////////////////////////////
  logic [spi_pkg::word_width-1:0] rx_sr;
  logic [spi_pkg::cnt_width-1:0]  bit_cnt;
  logic                           last_bit;

  assign last_bit = (bit_cnt == spi_pkg::cnt_width'(spi_pkg::word_width - 1));

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rx_sr       <= '0;
      bit_cnt     <= '0;
      rx_valid    <= 1'b0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end else begin
      rx_valid    <= sclk_fall & last_bit;
      frame_start <= cs_fall;
      frame_end   <= cs_rise;
      if (cs_sync) begin
        bit_cnt <= '0;              // partial word is dropped here
      end else if (sclk_fall) begin
        rx_sr   <= {rx_sr[spi_pkg::word_width-2:0], mosi_sync};
        bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
      end
    end
  end

  assign rx_word = rx_sr;           // stable until next falling edge

  ////////////////////////////////////////
  // transmit side, msb first on rising sclk
  ////////////////////////////////////////
  logic [spi_pkg::word_width-1:0] tx_sr;
  logic                           reload; // decoder updates tx_word on rx_valid

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      tx_sr  <= '0;
      reload <= 1'b0;
      miso   <= 1'b0;
    end else begin
      reload <= rx_valid;
      if (cs_sync) begin
        miso <= 1'b0;               // quiet line between frames
      end
      if (cs_fall || reload) begin
        tx_sr <= tx_word;
      end else if (sclk_rise) begin
        miso  <= tx_sr[spi_pkg::word_width-1];
        tx_sr <= {tx_sr[spi_pkg::word_width-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_spi_reg_slave.sv
`timescale 1ns/1ns
`default_nettype none

module tb_spi_reg_slave;

  logic        rst;            // system clock
  logic        clk;            // async active high reset
  logic        sclk;
  logic        mosi;
  logic        cs_n;
  logic        miso;
  logic        reg_write;
  logic [3:0]  reg_addr;
  logic [7:0]  reg_data;

  logic [7:0]  model [16];     // expected register contents without the id overlay
  logic [7:0]  tx_q[$];        // frame to send with the command first
  logic [7:0]  rx_q[$];        // complete words seen on miso
  logic [7:0]  exp_miso_q[$];
  logic [11:0] exp_wr_q[$];    // {addr, data} of strobes still due
  logic [11:0] wr_exp;

  spi_reg_slave dut0 (
    .rst(rst), .clk(clk),
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .miso(miso),
    .reg_write(reg_write), .reg_addr(reg_addr), .reg_data(reg_data)
  );

  always #10 rst = ~rst;       // 20 ns period

  ////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////
  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // model the first n_full words of tx_q and fill the expected queues
  function automatic void model_frame(input int n_full);
    logic [1:0] op;
    logic [3:0] ptr;
    exp_miso_q.delete();
    op  = tx_q[0][7:6];
    ptr = tx_q[0][3:0];
    exp_miso_q.push_back(8'h00);           // command slot sends 0
    for (int i = 1; i < n_full; i++) begin
      if (op == 2'b10) begin               // read burst where id reads back as a5
        exp_miso_q.push_back((ptr == 4'd15) ? 8'hA5 : model[ptr]);
        ptr++;
      end else begin
        exp_miso_q.push_back(8'h00);
        if (op == 2'b01) begin
          if (ptr != 4'd15) begin          // id write gives nothing
            model[ptr] = tx_q[i];
            exp_wr_q.push_back({ptr, tx_q[i]});
          end
          ptr++;                           // wraps at 16
        end
      end
    end
  endfunction

  // every accepted write must match the next expected strobe
  always @(posedge rst) begin
    if (reg_write) begin
      if (exp_wr_q.size() == 0) begin
        $display("reg_write fired at %0t ns with no write expected", $time);
        abort_run();
      end else begin
        wr_exp = exp_wr_q.pop_front();
        compare("reg_addr", reg_addr, wr_exp[11:8]);
        compare("reg_data", reg_data, wr_exp[7:0]);
      end
    end
  end

  ////////////////////////////////////////
  // spi master in mode 1
  ////////////////////////////////////////
  // sclk half period is 4 clocks
  // abort_bits cuts the last word short
  task automatic spi_frame(input int abort_bits);
    logic [7:0] w;
    logic [7:0] r;
    int         nb;
    rx_q.delete();
    @(posedge rst);
    cs_n <= 1'b0;
    repeat (4) @(posedge rst);             // let the select settle
    for (int i = 0; i < tx_q.size(); i++) begin
      w  = tx_q[i];
      r  = '0;
      nb = (i == tx_q.size() - 1 && abort_bits != 0) ? abort_bits : 8;
      for (int b = 7; b >= 8 - nb; b--) begin
        @(posedge rst);
        sclk <= 1'b1;                      // mosi changes with the rising edge
        mosi <= w[b];
        repeat (3) @(posedge rst);
        @(posedge rst);
        r[b] = miso;                       // sample just before falling edge
        sclk <= 1'b0;
        repeat (3) @(posedge rst);
      end
      if (nb == 8) rx_q.push_back(r);
    end
    repeat (4) @(posedge rst);
    cs_n <= 1'b1;
    repeat (6) @(posedge rst);             // idle gap between frames
  endtask

  task automatic wait_writes_done();
    int n;
    n = 0;
    while (exp_wr_q.size() != 0) begin
      @(posedge rst);
      n++;
      if (n > 50) begin
        $display("timed out waiting for %0d reg_write strobes", exp_wr_q.size());
        abort_run();
      end
    end
  endtask

  // send tx_q and check miso words and write strobes
  task automatic run_frame(input int abort_bits);
    model_frame((abort_bits != 0) ? tx_q.size() - 1 : tx_q.size());
    spi_frame(abort_bits);
    compare("miso word count", rx_q.size(), exp_miso_q.size());
    for (int i = 0; i < rx_q.size(); i++) begin
      compare($sformatf("miso word %0d", i), rx_q[i], exp_miso_q[i]);
    end
    wait_writes_done();
  endtask

  task automatic read_all();
    tx_q.delete();
    tx_q.push_back(8'h80);                 // read from address 0
    repeat (16) tx_q.push_back(8'($urandom));
    run_frame(0);
  endtask

  ////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////
  initial begin
    logic [3:0] start;
    int         n;
    int         cut;
    void'($urandom(32'h34ce_ced4));
    rst  = 1'b0;
    clk  = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    cs_n = 1'b1;
    for (int i = 0; i < 16; i++) model[i] = 8'h00;
    repeat (2) @(posedge rst);
    clk <= 1'b0;

    read_all();                            // reset values
    start = $urandom_range(6, 15);         // burst crosses address 15
    tx_q.delete();
    tx_q.push_back({4'b0100, start});
    repeat (10) tx_q.push_back(8'($urandom));
    run_frame(0);
    tx_q.delete();
    tx_q.push_back({4'b1000, start});      // readback wraps too
    repeat (16) tx_q.push_back(8'($urandom));
    run_frame(0);

    tx_q.delete();                         // opcode 00 then 11
    tx_q.push_back({4'b0000, 4'($urandom)});
    repeat (4) tx_q.push_back(8'($urandom));
    run_frame(0);
    tx_q[0] = {4'b1100, 4'($urandom)};
    run_frame(0);
    read_all();

    tx_q.delete();                         // last data word cut after 5 bits
    tx_q.push_back({4'b0100, 4'($urandom_range(0, 10))});
    repeat (4) tx_q.push_back(8'($urandom));
    run_frame(5);
    read_all();

    for (int f = 0; f < 40; f++) begin
      n = $urandom_range(1, 6);
      tx_q.delete();
      tx_q.push_back(8'($urandom));        // any opcode and any address
      repeat (n) tx_q.push_back(8'($urandom));
      cut = ($urandom_range(0, 7) == 0) ? $urandom_range(1, 7) : 0;
      run_frame(cut);
    end
    read_all();

    repeat (10) @(posedge rst);            // stray strobes during idle trip the monitor
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
